// ==== bench/sigmoidTb.sv ====
`timescale 1ns/1ps

module sigmoidTb;

	localparam int ResetCycles = 5;
	// Cycles from the cycle a sample is presented to the cycle its word is out
	localparam int Latency = 6;
	localparam int TableLen = 27;
	localparam int RandomCount = 200;
	localparam int DrainCount = 4;
	localparam int CycleLimit = ResetCycles + Latency + TableLen + RandomCount
		+ DrainCount * (Latency + 4) + 20;

	// Reference copies of the segment tables
	localparam logic [3:0] SlopeRef [0:7] = '{4'd15, 4'd14, 4'd11, 4'd8, 4'd6, 4'd4, 4'd2, 4'd1};
	localparam logic [11:0] InterceptRef [0:7] = '{
		12'd1027, 12'd1053, 12'd1150, 12'd1295, 12'd1419, 12'd1572, 12'd1762, 12'd1880
	};

	typedef struct packed {
		logic [1:0]        group;
		logic signed [7:0] x;
		logic              valid;
	} stimulus_t;

	typedef struct packed {
		logic [15:0] y;
		int          cycle;
	} expected_t;

	// Group 1 positive, group 2 negative, group 3 streaming with gaps
	localparam stimulus_t StimTable [0:TableLen-1] = '{
		'{2'd1, 8'sd0, 1'b1},    '{2'd1, 8'sd1, 1'b1},    '{2'd1, 8'sd15, 1'b1},
		'{2'd1, 8'sd16, 1'b1},   '{2'd1, 8'sd32, 1'b1},   '{2'd1, 8'sd47, 1'b1},
		'{2'd1, 8'sd63, 1'b1},   '{2'd1, 8'sd64, 1'b1},   '{2'd1, 8'sd80, 1'b1},
		'{2'd1, 8'sd95, 1'b1},   '{2'd1, 8'sd111, 1'b1},  '{2'd1, 8'sd112, 1'b1},
		'{2'd1, 8'sd127, 1'b1},  '{2'd2, -8'sd1, 1'b1},   '{2'd2, -8'sd16, 1'b1},
		'{2'd2, -8'sd100, 1'b1}, '{2'd2, -8'sd127, 1'b1}, '{2'd2, 8'h80, 1'b1},
		'{2'd3, 8'sd5, 1'b1},    '{2'd3, 8'sd20, 1'b1},   '{2'd3, 8'sd33, 1'b0},
		'{2'd3, -8'sd50, 1'b1},  '{2'd3, 8'sd70, 1'b0},   '{2'd3, 8'sd70, 1'b0},
		'{2'd3, 8'sd100, 1'b1},  '{2'd3, -8'sd90, 1'b1},  '{2'd3, 8'h80, 1'b1}
	};

	logic              clk;
	logic              i_rst;
	logic              i_inValid;
	logic signed [7:0] i_x;
	logic [15:0]       o_y;
	logic              o_outValid;

	expected_t   scoreboard [$];
	int          cycleCount;
	int          checkCount;
	int          errorCount;
	logic [31:0] lfsrState;

	sigmoidTop dut_i (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_inValid  (i_inValid),
		.i_x        (i_x),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Sigmoid word from the segment rules
	function automatic logic [15:0] expectedWord(logic signed [7:0] x);
		logic        sgn;
		logic [7:0]  mag;
		logic [2:0]  seg;
		logic [11:0] f;
		logic [10:0] m;
		sgn = x[7];
		mag = sgn ? (8'd0 - $unsigned(x)) : $unsigned(x);
		seg = mag[7] ? 3'd7 : mag[6:4];
		f = {4'b0, mag} * {8'b0, SlopeRef[seg]} + InterceptRef[seg];
		// Negative side is the bitwise mirror
		m = f[10:0] ^ {11{sgn}};
		return {1'b0, m, sgn, 3'b011};
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic applySample(input logic signed [7:0] x, input logic valid);
		expected_t entry;
		@(posedge clk);
		#1;
		i_x = x;
		i_inValid = valid;
		if (valid) begin
			entry.y = expectedWord(x);
			entry.cycle = cycleCount + Latency;
			scoreboard.push_back(entry);
		end
	endtask

	task automatic drainPipeline();
		@(posedge clk);
		#1;
		i_inValid = 1'b0;
		while (scoreboard.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("Test %s finished with %0d errors", name, errorCount - startErrors);
	endtask

	task automatic runGroup(input logic [1:0] group, input string name);
		int startErrors;
		startErrors = errorCount;
		for (int i = 0; i < TableLen; i++) begin
			if (StimTable[i].group == group) begin
				applySample(StimTable[i].x, StimTable[i].valid);
			end
		end
		drainPipeline();
		reportTest(name, startErrors);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("The run timed out after %0d cycles", cycleCount);
			$display("** FAIL **");
			$finish;
		end
	end

	// Output checker, compares each cycle against the scoreboard front
	always @(negedge clk) begin : outputMonitor
		logic      expectValid;
		expected_t entry;
		expectValid = (scoreboard.size() != 0) && (scoreboard[0].cycle == cycleCount);
		checkCount++;
		assert (o_outValid == expectValid) else begin
			errorCount++;
			$display("Error at %0t: o_outValid is %0b, expected %0b in cycle %0d",
				$time, o_outValid, expectValid, cycleCount);
		end
		if (expectValid) begin
			entry = scoreboard.pop_front();
			if (o_outValid) begin
				checkCount++;
				assert (o_y == entry.y) else begin
					errorCount++;
					$display("Error at %0t: o_y is %h, expected %h", $time, o_y, entry.y);
				end
			end
		end
	end

	initial begin
		int          startErrors;
		logic [31:0] xBits;
		logic [31:0] validBits;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		lfsrState = 32'h2f2f_a5fd;
		i_rst = 1'b1;
		i_inValid = 1'b0;
		i_x = '0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		i_rst = 1'b0;

		// No valid output in the idle cycles after reset
		startErrors = errorCount;
		repeat (Latency) begin
			@(posedge clk);
			#1;
			checkCount++;
			assert (!o_outValid) else begin
				errorCount++;
				$display("Error at %0t: o_outValid high after reset", $time);
			end
		end
		reportTest("reset", startErrors);

		runGroup(2'd1, "positive");
		runGroup(2'd2, "negative");
		runGroup(2'd3, "streaming");

		startErrors = errorCount;
		for (int i = 0; i < RandomCount; i++) begin
			takeBits(8, xBits);
			takeBits(1, validBits);
			applySample(xBits[7:0], validBits[0]);
		end
		drainPipeline();
		reportTest("random", startErrors);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== files.f ====
verilog/sigmoidPkg.sv
verilog/magnitudeStage.sv
verilog/segmentLookup.sv
verilog/slopeMultiply.sv
verilog/interceptAdd.sv
verilog/outputFormat.sv
verilog/sigmoidTop.sv
bench/sigmoidTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the simulator with assertions enabled
verilator --binary --assert --top-module sigmoidTb -f files.f -Mdir obj_dir

# Keep the output even when the simulator stops on an error
output="$(./obj_dir/VsigmoidTb 2>&1 || true)"
echo "$output"

if grep -qxF '** PASS **' <<< "$output"; then
	exit 0
else
	echo "Simulation did not pass"
	exit 1
fi

// ==== verilog/interceptAdd.sv ====
`timescale 1ns/1ps

module interceptAdd
	import sigmoidPkg::*;
(
	input  logic           clk,
	input  logic           i_rst,
	input  productStage_t  i_stage,
	output functionStage_t o_stage
);

	logic [InterceptWidth-1:0] funcValue;

	// Wraps modulo 4096
	assign funcValue = i_stage.product + i_stage.intercept;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_stage <= '0;
		end else begin
			o_stage.valid     <= i_stage.valid;
			o_stage.sign      <= i_stage.sign;
			o_stage.funcValue <= funcValue;
		end
	end

endmodule

// ==== verilog/magnitudeStage.sv ====
`timescale 1ns/1ps

module magnitudeStage
	import sigmoidPkg::*;
(
	input  logic                      clk,
	input  logic                      i_rst,
	input  logic                      i_inValid,
	input  logic signed [InWidth-1:0] i_x,
	output magnitudeStage_t           o_stage
);

	logic               sign;
	logic [InWidth-1:0] magnitude;

	// Sign is the top input bit
	assign sign = i_x[InWidth-1];

	// Two's-complement negation for negative inputs
	// -128 wraps to 8'h80, read as unsigned 128
	always_comb begin
		if (sign) begin
			magnitude = ~$unsigned(i_x) + 1'b1;
		end else begin
			magnitude = $unsigned(i_x);
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_stage <= '0;
		end else begin
			o_stage.valid     <= i_inValid;
			o_stage.sign      <= sign;
			o_stage.magnitude <= magnitude;
		end
	end

endmodule

// ==== verilog/outputFormat.sv ====
`timescale 1ns/1ps

module outputFormat
	import sigmoidPkg::*;
(
	input  logic                clk,
	input  logic                i_rst,
	input  functionStage_t      i_stage,
	output logic [OutWidth-1:0] o_y,
	output logic                o_outValid
);

	logic [MirrorWidth-1:0] mirrored;
	logic [OutWidth-1:0]    outWord;

	// Negative inputs give one minus the positive result,
	// approximated by inverting the value bits
	assign mirrored = i_stage.funcValue[MirrorWidth-1:0] ^ {MirrorWidth{i_stage.sign}};

	// Zero, value, sign, fixed low bits
	assign outWord = {1'b0, mirrored, i_stage.sign, OutLowBits};

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_y        <= '0;
			o_outValid <= 1'b0;
		end else begin
			o_y        <= outWord;
			o_outValid <= i_stage.valid;
		end
	end

	// Top bit of the output word is reserved
	topBitZero: assert property (
		@(posedge clk) disable iff (i_rst)
		!o_y[OutWidth-1]
	) else $error("outputFormat: o_y bit 15 set");

endmodule

// ==== verilog/segmentLookup.sv ====
`timescale 1ns/1ps

module segmentLookup
	import sigmoidPkg::*;
(
	input  logic            clk,
	input  logic            i_rst,
	input  magnitudeStage_t i_stage,
	output segmentStage_t   o_stage
);

	logic [SegmentWidth-1:0]   segment;
	logic [SlopeWidth-1:0]     slope;
	logic [InterceptWidth-1:0] intercept;

	// Segment from magnitude bits 6..4
	// Only 128 sets bit 7, and it belongs in the last segment
	always_comb begin
		if (i_stage.magnitude[InWidth-1]) begin
			segment = SegmentWidth'(SegmentCount - 1);
		end else begin
			segment = i_stage.magnitude[InWidth-2 -: SegmentWidth];
		end
	end

	// Table reads
	assign slope     = SlopeTable[segment];
	assign intercept = InterceptTable[segment];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_stage <= '0;
		end else begin
			o_stage.valid     <= i_stage.valid;
			o_stage.sign      <= i_stage.sign;
			o_stage.magnitude <= i_stage.magnitude;
			o_stage.slope     <= slope;
			o_stage.intercept <= intercept;
		end
	end

	// A valid sample always leaves with a usable slope
	slopeValid: assert property (
		@(posedge clk) disable iff (i_rst)
		o_stage.valid |-> (o_stage.slope != '0)
	) else $error("segmentLookup: valid sample left with zero slope");

endmodule

// ==== verilog/sigmoidPkg.sv ====
package sigmoidPkg;

	// Datapath widths
	localparam int InWidth = 8;
	localparam int SlopeWidth = 4;
	localparam int InterceptWidth = 12;
	localparam int PartialWidth = 10;
	localparam int OutWidth = 16;
	localparam int SegmentCount = 8;
	localparam int SegmentWidth = $clog2(SegmentCount);

	// Output word layout
	// Bit 15 zero, bits 14..4 function value, bit 3 sign, bits 2..0 fixed
	localparam int MirrorWidth = 11;
	localparam int LowBitsWidth = 3;
	localparam logic [LowBitsWidth-1:0] OutLowBits = 3'b011;

	// Largest product the slope table can yield (128 times 15)
	localparam int MaxProduct = 1920;

	// Slope per segment, steepest at the origin
	localparam logic [SlopeWidth-1:0] SlopeTable [0:SegmentCount-1] = '{
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// Intercept per segment
	// Top two bits are always 01, so every entry sits between 1024 and 2047
	localparam logic [InterceptWidth-1:0] InterceptTable [0:SegmentCount-1] = '{
		12'd1027,
		12'd1053,
		12'd1150,
		12'd1295,
		12'd1419,
		12'd1572,
		12'd1762,
		12'd1880
	};

	// After stage 0
	typedef struct packed {
		logic                valid;
		logic                sign;
		logic [InWidth-1:0]  magnitude;
	} magnitudeStage_t;

	// After stage 1
	typedef struct packed {
		logic                      valid;
		logic                      sign;
		logic [InWidth-1:0]        magnitude;
		logic [SlopeWidth-1:0]     slope;
		logic [InterceptWidth-1:0] intercept;
	} segmentStage_t;

	// After stage 2, two partial sums of the slope product
	typedef struct packed {
		logic                      valid;
		logic                      sign;
		logic [InterceptWidth-1:0] intercept;
		logic [PartialWidth-1:0]   lowPair;
		logic [PartialWidth-1:0]   highPair;
	} partialStage_t;

	// After stage 3
	typedef struct packed {
		logic                      valid;
		logic                      sign;
		logic [InterceptWidth-1:0] intercept;
		logic [InterceptWidth-1:0] product;
	} productStage_t;

	// After stage 4
	typedef struct packed {
		logic                      valid;
		logic                      sign;
		logic [InterceptWidth-1:0] funcValue;
	} functionStage_t;

endpackage

// ==== verilog/sigmoidTop.sv ====
`timescale 1ns/1ps

module sigmoidTop
	import sigmoidPkg::*;
(
	input  logic                       clk,
	input  logic                       i_rst,
	input  logic                       i_inValid,
	input  logic signed [InWidth-1:0]  i_x,
	output logic        [OutWidth-1:0] o_y,
	output logic                       o_outValid
);

	// Stage-to-stage payloads, each carries its own valid bit
	magnitudeStage_t magStage;
	segmentStage_t   segStage;
	productStage_t   prodStage;
	functionStage_t  funcStage;

	// Stage 0
	magnitudeStage magnitudeStage_i (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_inValid (i_inValid),
		.i_x       (i_x),
		.o_stage   (magStage)
	);

	// Stage 1
	segmentLookup segmentLookup_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_stage (magStage),
		.o_stage (segStage)
	);

	// Stages 2 and 3
	slopeMultiply slopeMultiply_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_stage (segStage),
		.o_stage (prodStage)
	);

	// Stage 4
	interceptAdd interceptAdd_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_stage (prodStage),
		.o_stage (funcStage)
	);

	// Stage 5
	outputFormat outputFormat_i (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_stage    (funcStage),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

endmodule

// ==== verilog/slopeMultiply.sv ====
`timescale 1ns/1ps

module slopeMultiply
	import sigmoidPkg::*;
(
	input  logic          clk,
	input  logic          i_rst,
	input  segmentStage_t i_stage,
	output productStage_t o_stage
);

	// Magnitude gated by each slope bit
	logic [InWidth-1:0]        term0;
	logic [InWidth-1:0]        term1;
	logic [InWidth-1:0]        term2;
	logic [InWidth-1:0]        term3;
	logic [PartialWidth-1:0]   lowPair;
	logic [PartialWidth-1:0]   highPair;
	logic [InterceptWidth-1:0] product;
	partialStage_t             partial;

	assign term0 = i_stage.magnitude & {InWidth{i_stage.slope[0]}};
	assign term1 = i_stage.magnitude & {InWidth{i_stage.slope[1]}};
	assign term2 = i_stage.magnitude & {InWidth{i_stage.slope[2]}};
	assign term3 = i_stage.magnitude & {InWidth{i_stage.slope[3]}};

	// First level weights the two terms of each pair by 1 and 2
	// The high pair is scaled by four again in the second level
	assign lowPair  = PartialWidth'(term0) + (PartialWidth'(term1) << 1);
	assign highPair = PartialWidth'(term2) + (PartialWidth'(term3) << 1);

	// Stage 2 register
	always_ff @(posedge clk) begin
		if (i_rst) begin
			partial <= '0;
		end else begin
			partial.valid     <= i_stage.valid;
			partial.sign      <= i_stage.sign;
			partial.intercept <= i_stage.intercept;
			partial.lowPair   <= lowPair;
			partial.highPair  <= highPair;
		end
	end

	// Second level truncated to 12 bits
	assign product = InterceptWidth'(partial.lowPair)
		+ (InterceptWidth'(partial.highPair) << 2);

	// Stage 3 register
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_stage <= '0;
		end else begin
			o_stage.valid     <= partial.valid;
			o_stage.sign      <= partial.sign;
			o_stage.intercept <= partial.intercept;
			o_stage.product   <= product;
		end
	end

	// Largest magnitude times largest slope bounds the product
	productRange: assert property (
		@(posedge clk) disable iff (i_rst)
		o_stage.valid |-> (o_stage.product <= InterceptWidth'(MaxProduct))
	) else $error("slopeMultiply: product %0d out of range", o_stage.product);

endmodule
